// ==== design/core_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, encodings and fixed addresses
// Only the RV32I subset the core decodes
// Trap target is fixed, no mtvec
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package core_pkg;

  // Datapath and instruction widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned ILEN = 32;

  // Register file addressing
  localparam int unsigned REG_BITS = 5;
  localparam int unsigned NUM_REGS = 32;

  // BTB geometry, word aligned PCs
  localparam int unsigned BTB_BITS    = 4;
  localparam int unsigned BTB_ENTRIES = 1 << BTB_BITS;
  localparam int unsigned BTB_TAG_LEN = XLEN - BTB_BITS - 2;

  // Reset fetch address and exception target
  localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0000;
  localparam logic [XLEN-1:0] TRAP_PC = 32'h0000_0100;

  // Minor opcode fields
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_BASE    = 7'b000_0000;
  localparam logic [6:0] F7_SUB     = 7'b010_0000;

  // Major opcodes in instr[6:0]
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    OP     = 7'b011_0011,
    BRANCH = 7'b110_0011,
    JAL    = 7'b110_1111
  } opcode_t;

  // mcause style exception codes
  typedef enum logic [3:0] {
    EXC_NONE          = 4'd0,
    EXC_ILLEGAL_INSTR = 4'd2
  } except_code_t;

endpackage

`default_nettype wire

// ==== design/fetch_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch channel, front end to back end
// Transfer on valid and ready both high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;

  logic                      valid;
  logic                      ready;
  logic [core_pkg::XLEN-1:0] pc;
  logic [core_pkg::ILEN-1:0] instr;
  // Prediction made when the word was requested
  logic                      pred_taken;
  logic [core_pkg::XLEN-1:0] pred_target;

  modport fe (output valid, pc, instr, pred_taken, pred_target, input ready);
  modport be (input valid, pc, instr, pred_taken, pred_target, output ready);

endinterface

`default_nettype wire

// ==== design/resolve_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch resolution, back end to front end
// valid pulses once per retired branch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface resolve_if;

  logic                      valid;
  logic [core_pkg::XLEN-1:0] pc;
  // Taken target, also for not-taken branches
  logic [core_pkg::XLEN-1:0] target;
  logic                      taken;
  // Predicted next PC was wrong
  logic                      mispredict;

  modport be (output valid, pc, target, taken, mispredict);
  modport fe (input valid, pc, target, taken, mispredict);

endinterface

`default_nettype wire

// ==== design/branch_predictor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct mapped BTB with 2-bit counters
// Lookup is combinational on lookup_pc_i
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [core_pkg::XLEN-1:0] lookup_pc_i,
  output logic                      pred_taken_o,
  output logic [core_pkg::XLEN-1:0] pred_target_o,
  input  logic                      upd_valid_i,
  input  logic [core_pkg::XLEN-1:0] upd_pc_i,
  input  logic [core_pkg::XLEN-1:0] upd_target_i,
  input  logic                      upd_taken_i
);

  logic [core_pkg::BTB_ENTRIES-1:0] valid_q;
  logic [core_pkg::BTB_TAG_LEN-1:0] tag_q    [core_pkg::BTB_ENTRIES];
  logic [core_pkg::XLEN-1:0]        target_q [core_pkg::BTB_ENTRIES];
  logic [1:0]                       cnt_q    [core_pkg::BTB_ENTRIES];
  logic [core_pkg::BTB_BITS-1:0]    lk_idx;
  logic [core_pkg::BTB_BITS-1:0]    up_idx;
  logic                             lk_hit;
  logic                             up_hit;

  // Index skips the two byte offset bits
  assign lk_idx = lookup_pc_i[core_pkg::BTB_BITS+1:2];
  assign up_idx = upd_pc_i[core_pkg::BTB_BITS+1:2];
  assign lk_hit = valid_q[lk_idx] &&
                  (tag_q[lk_idx] == lookup_pc_i[core_pkg::XLEN-1:core_pkg::BTB_BITS+2]);
  assign up_hit = valid_q[up_idx] &&
                  (tag_q[up_idx] == upd_pc_i[core_pkg::XLEN-1:core_pkg::BTB_BITS+2]);

  // Taken on a hit with counter in the upper half
  assign pred_taken_o  = lk_hit && cnt_q[lk_idx][1];
  assign pred_target_o = target_q[lk_idx];

  // Entry valid bits, set when a taken outcome allocates
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (upd_valid_i && upd_taken_i) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (upd_valid_i) begin
      if (upd_taken_i && !up_hit) begin
        // New entry starts weakly taken
        tag_q[up_idx]    <= upd_pc_i[core_pkg::XLEN-1:core_pkg::BTB_BITS+2];
        target_q[up_idx] <= upd_target_i;
        cnt_q[up_idx]    <= 2'b10;
      end else if (upd_taken_i) begin
        target_q[up_idx] <= upd_target_i;
        if (cnt_q[up_idx] != 2'b11) cnt_q[up_idx] <= cnt_q[up_idx] + 2'd1;
      end else if (up_hit && cnt_q[up_idx] != 2'b00) begin
        cnt_q[up_idx] <= cnt_q[up_idx] - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/front_end.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC generation and i-cache fetch
// One outstanding request, one buffer slot
// Redirect flushes the buffer at once
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module front_end (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  output logic [core_pkg::XLEN-1:0] addr_o,
  output logic                      addr_valid_o,
  input  logic                      addr_ready_i,
  input  logic [core_pkg::ILEN-1:0] data_i,
  input  logic                      data_valid_i,
  output logic                      data_ready_o,
  fetch_if.fe                       fetch,
  resolve_if.fe                     res,
  input  logic                      except_i,
  input  logic [core_pkg::XLEN-1:0] except_pc_i
);

  logic [core_pkg::XLEN-1:0] pc_q;
  logic [core_pkg::XLEN-1:0] next_pc;
  logic [core_pkg::XLEN-1:0] mispred_pc;
  logic                      redirect;
  logic                      pred_taken;
  logic [core_pkg::XLEN-1:0] pred_target;
  logic                      addr_hs;
  logic                      rsp;
  logic                      keep_rsp;
  logic                      fetch_xfer;
  logic                      wait_q;
  logic                      drop_q;
  // Request in flight and its prediction
  logic [core_pkg::XLEN-1:0] inf_pc_q;
  logic                      inf_taken_q;
  logic [core_pkg::XLEN-1:0] inf_target_q;
  // Fetch buffer
  logic                      buf_valid_q;
  logic [core_pkg::XLEN-1:0] buf_pc_q;
  logic [core_pkg::ILEN-1:0] buf_instr_q;
  logic                      buf_taken_q;
  logic [core_pkg::XLEN-1:0] buf_target_q;

  branch_predictor u_btb (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lookup_pc_i   (pc_q),
    .pred_taken_o  (pred_taken),
    .pred_target_o (pred_target),
    .upd_valid_i   (res.valid),
    .upd_pc_i      (res.pc),
    .upd_target_i  (res.target),
    .upd_taken_i   (res.taken)
  );

  assign redirect   = except_i | res.mispredict;
  assign mispred_pc = res.taken ? res.target : res.pc + 32'd4;
  assign addr_hs    = addr_valid_o & addr_ready_i;
  assign rsp        = data_valid_i & wait_q;
  // Words of requests issued before a redirect are discarded
  assign keep_rsp   = rsp & ~drop_q & ~redirect;
  assign fetch_xfer = buf_valid_q & fetch.ready;
  // Buffer is free, or drains this cycle
  assign data_ready_o = ~buf_valid_q | fetch.ready;
  assign addr_o       = pc_q;

  // Exception, then mispredict, then BTB, then sequential
  always_comb begin
    if (except_i) begin
      next_pc = except_pc_i;
    end else if (res.mispredict) begin
      next_pc = mispred_pc;
    end else if (addr_hs) begin
      next_pc = pred_taken ? pred_target : pc_q + 32'd4;
    end else begin
      next_pc = pc_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q         <= core_pkg::BOOT_PC;
      addr_valid_o <= 1'b0;
      wait_q       <= 1'b0;
      drop_q       <= 1'b0;
      buf_valid_q  <= 1'b0;
    end else begin
      pc_q <= next_pc;
      // Request FSM, idle to request to wait
      if (addr_hs) begin
        addr_valid_o <= 1'b0;
        wait_q       <= 1'b1;
      end else if (!addr_valid_o && (!wait_q || rsp)) begin
        addr_valid_o <= 1'b1;
        wait_q       <= 1'b0;
      end
      // Stale request still pending
      if (redirect && (addr_hs || (wait_q && !rsp))) drop_q <= 1'b1;
      else if (rsp) drop_q <= 1'b0;
      if (redirect) buf_valid_q <= 1'b0;
      else if (keep_rsp) buf_valid_q <= 1'b1;
      else if (fetch_xfer) buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (addr_hs) begin
      inf_pc_q     <= pc_q;
      inf_taken_q  <= pred_taken;
      inf_target_q <= pred_target;
    end
    if (keep_rsp) begin
      buf_pc_q     <= inf_pc_q;
      buf_instr_q  <= data_i;
      buf_taken_q  <= inf_taken_q;
      buf_target_q <= inf_target_q;
    end
  end

  assign fetch.valid       = buf_valid_q;
  assign fetch.pc          = buf_pc_q;
  assign fetch.instr       = buf_instr_q;
  assign fetch.pred_taken  = buf_taken_q;
  assign fetch.pred_target = buf_target_q;

endmodule

`default_nettype wire

// ==== design/back_end.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode, register file, single cycle ALU
// ADDI ADD SUB BEQ BNE JAL, rest is illegal
// Results registered the cycle after accept
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module back_end (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  fetch_if.be                           fetch,
  resolve_if.be                         res,
  output logic                          except_o,
  output logic [core_pkg::XLEN-1:0]     except_pc_o,
  output logic                          commit_valid_o,
  output logic [core_pkg::XLEN-1:0]     commit_pc_o,
  output logic [core_pkg::REG_BITS-1:0] commit_rd_o,
  output logic [core_pkg::XLEN-1:0]     commit_data_o,
  output logic                          except_raised_o,
  output core_pkg::except_code_t        except_code_o
);

  logic [core_pkg::XLEN-1:0]     rf_q [core_pkg::NUM_REGS];
  core_pkg::opcode_t             opcode;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [core_pkg::REG_BITS-1:0] rd;
  logic [core_pkg::REG_BITS-1:0] rs1;
  logic [core_pkg::REG_BITS-1:0] rs2;
  logic [core_pkg::XLEN-1:0]     op_a;
  logic [core_pkg::XLEN-1:0]     op_b;
  logic [core_pkg::XLEN-1:0]     imm_i;
  logic [core_pkg::XLEN-1:0]     imm_b;
  logic [core_pkg::XLEN-1:0]     imm_j;
  logic [core_pkg::XLEN-1:0]     seq_pc;
  logic [core_pkg::XLEN-1:0]     br_target;
  logic [core_pkg::XLEN-1:0]     next_pc;
  logic [core_pkg::XLEN-1:0]     pred_next_pc;
  logic [core_pkg::XLEN-1:0]     result;
  logic                          legal;
  logic                          is_ctrl;
  logic                          writes_rd;
  logic                          taken;
  logic                          accept;
  logic                          res_valid_q;
  logic                          redirect_q;
  logic                          except_q;
  logic [core_pkg::XLEN-1:0]     res_pc_q;
  logic [core_pkg::XLEN-1:0]     res_target_q;
  logic                          res_taken_q;

  // Field extraction
  assign opcode = core_pkg::opcode_t'(fetch.instr[6:0]);
  assign funct3 = fetch.instr[14:12];
  assign funct7 = fetch.instr[31:25];
  assign rd     = fetch.instr[11:7];
  assign rs1    = fetch.instr[19:15];
  assign rs2    = fetch.instr[24:20];
  assign imm_i  = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
  assign imm_b  = {{19{fetch.instr[31]}}, fetch.instr[31], fetch.instr[7],
                   fetch.instr[30:25], fetch.instr[11:8], 1'b0};
  assign imm_j  = {{11{fetch.instr[31]}}, fetch.instr[31], fetch.instr[19:12],
                   fetch.instr[20], fetch.instr[30:21], 1'b0};

  // x0 is hardwired to zero on read
  assign op_a   = (rs1 == '0) ? '0 : rf_q[rs1];
  assign op_b   = (rs2 == '0) ? '0 : rf_q[rs2];
  assign seq_pc = fetch.pc + 32'd4;

  always_comb begin
    legal     = 1'b0;
    is_ctrl   = 1'b0;
    writes_rd = 1'b0;
    taken     = 1'b0;
    result    = '0;
    br_target = seq_pc;
    case (opcode)
      core_pkg::OP_IMM: begin
        if (funct3 == core_pkg::F3_ADD_SUB) begin
          legal     = 1'b1;
          writes_rd = 1'b1;
          result    = op_a + imm_i;
        end
      end
      core_pkg::OP: begin
        if (funct3 == core_pkg::F3_ADD_SUB && funct7 == core_pkg::F7_BASE) begin
          legal     = 1'b1;
          writes_rd = 1'b1;
          result    = op_a + op_b;
        end else if (funct3 == core_pkg::F3_ADD_SUB && funct7 == core_pkg::F7_SUB) begin
          legal     = 1'b1;
          writes_rd = 1'b1;
          result    = op_a - op_b;
        end
      end
      core_pkg::BRANCH: begin
        if (funct3 == core_pkg::F3_BEQ || funct3 == core_pkg::F3_BNE) begin
          legal     = 1'b1;
          is_ctrl   = 1'b1;
          br_target = fetch.pc + imm_b;
          taken     = (funct3 == core_pkg::F3_BNE) ? (op_a != op_b) : (op_a == op_b);
        end
      end
      core_pkg::JAL: begin
        // Link value is the return address
        legal     = 1'b1;
        is_ctrl   = 1'b1;
        writes_rd = 1'b1;
        taken     = 1'b1;
        br_target = fetch.pc + imm_j;
        result    = seq_pc;
      end
      default: ;
    endcase
  end

  assign next_pc      = taken ? br_target : seq_pc;
  assign pred_next_pc = fetch.pred_taken ? fetch.pred_target : seq_pc;
  assign accept       = fetch.valid & fetch.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      commit_valid_o <= 1'b0;
      res_valid_q    <= 1'b0;
      redirect_q     <= 1'b0;
      except_q       <= 1'b0;
    end else begin
      commit_valid_o <= accept & legal;
      res_valid_q    <= accept & legal & is_ctrl;
      redirect_q     <= accept & legal & (next_pc != pred_next_pc);
      except_q       <= accept & ~legal;
    end
  end

  // Commit data is the value written, zero for rd = x0
  always_ff @(posedge clk_i) begin
    if (accept) begin
      commit_pc_o   <= fetch.pc;
      commit_rd_o   <= writes_rd ? rd : '0;
      commit_data_o <= (writes_rd && rd != '0) ? result : '0;
      res_pc_q      <= fetch.pc;
      res_target_q  <= br_target;
      res_taken_q   <= taken;
    end
    if (accept && legal && writes_rd && rd != '0) rf_q[rd] <= result;
  end

  // No accept while a redirect is on the wires
  assign fetch.ready     = ~(redirect_q | except_q);
  assign res.valid       = res_valid_q;
  assign res.pc          = res_pc_q;
  assign res.target      = res_target_q;
  assign res.taken       = res_taken_q;
  assign res.mispredict  = redirect_q;
  assign except_o        = except_q;
  assign except_pc_o     = core_pkg::TRAP_PC;
  assign except_raised_o = except_q;
  assign except_code_o   = except_q ? core_pkg::EXC_ILLEGAL_INSTR : core_pkg::EXC_NONE;

endmodule

`default_nettype wire

// ==== design/data_path.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top, only the i-cache port faces out
// i-cache must keep one request in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module data_path (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  output logic [31:0]            addr_o,
  output logic                   addr_valid_o,
  input  logic                   addr_ready_i,
  input  logic [31:0]            data_i,
  input  logic                   data_valid_i,
  output logic                   data_ready_o,
  output logic                   commit_valid_o,
  output logic [31:0]            commit_pc_o,
  output logic [4:0]             commit_rd_o,
  output logic [31:0]            commit_data_o,
  output logic                   except_raised_o,
  output core_pkg::except_code_t except_code_o
);

  // Exception redirect, back end to front end
  logic                      except;
  logic [core_pkg::XLEN-1:0] except_pc;

  fetch_if   fetch_bus ();
  resolve_if res_bus ();

  front_end u_front_end (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .addr_o       (addr_o),
    .addr_valid_o (addr_valid_o),
    .addr_ready_i (addr_ready_i),
    .data_i       (data_i),
    .data_valid_i (data_valid_i),
    .data_ready_o (data_ready_o),
    .fetch        (fetch_bus.fe),
    .res          (res_bus.fe),
    .except_i     (except),
    .except_pc_i  (except_pc)
  );

  back_end u_back_end (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch           (fetch_bus.be),
    .res             (res_bus.be),
    .except_o        (except),
    .except_pc_o     (except_pc),
    .commit_valid_o  (commit_valid_o),
    .commit_pc_o     (commit_pc_o),
    .commit_rd_o     (commit_rd_o),
    .commit_data_o   (commit_data_o),
    .except_raised_o (except_raised_o),
    .except_code_o   (except_code_o)
  );

endmodule

`default_nettype wire

// ==== verification/data_path_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i-cache port and fetch channel checks
// Fetch payload may drop only with valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module data_path_props (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        addr_valid_o,
  input logic        addr_ready_i,
  input logic        data_valid_i,
  input logic        commit_valid_o,
  input logic        except_raised_o,
  input logic        fetch_valid,
  input logic        fetch_ready,
  input logic [31:0] fetch_pc,
  input logic [31:0] fetch_instr
);

  // Accepted address still waiting for its word
  logic outstanding_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (addr_valid_o && addr_ready_i) begin
      outstanding_q <= 1'b1;
    end else if (data_valid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    addr_valid_o && !addr_ready_i |=> addr_valid_o)
    else $error("addr_valid_o dropped before addr_ready_i");

  a_commit_or_except: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(commit_valid_o && except_raised_o))
    else $error("commit and exception in the same cycle");

  // A redirect empties the buffer, anything else holds it
  a_fetch_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_valid && !fetch_ready |=> !fetch_valid || ($stable(fetch_pc) && $stable(fetch_instr)))
    else $error("fetch payload changed while stalled");

  a_one_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outstanding_q |-> !addr_valid_o)
    else $error("second i-cache request while one is outstanding");

endmodule

bind data_path data_path_props u_props (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .addr_valid_o    (addr_valid_o),
  .addr_ready_i    (addr_ready_i),
  .data_valid_i    (data_valid_i),
  .commit_valid_o  (commit_valid_o),
  .except_raised_o (except_raised_o),
  .fetch_valid     (fetch_bus.valid),
  .fetch_ready     (fetch_bus.ready),
  .fetch_pc        (fetch_bus.pc),
  .fetch_instr     (fetch_bus.instr)
);

`default_nettype wire

// ==== verification/tb_data_path.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random program in a 64 word i-cache model
// Control flow jumps forward and wraps at 64 words
// Stops at the first mismatch or timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_data_path;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] addr_o;
  logic        addr_valid_o;
  logic        addr_ready_i;
  logic [31:0] data_i;
  logic        data_valid_i;
  logic        data_ready_o;
  logic        commit_valid_o;
  logic [31:0] commit_pc_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_data_o;
  logic        except_raised_o;
  core_pkg::except_code_t except_code_o;

  integer      seed;
  logic [31:0] mem [64];
  // ISA model state
  logic [31:0] mreg [32];
  logic [31:0] mpc;
  // i-cache model state
  int unsigned acc_cnt;
  int unsigned acc_draw;
  logic        rsp_pend;
  int unsigned rsp_cnt;
  logic [31:0] rsp_addr;

  data_path UUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic int unsigned urand(input int unsigned n);
    urand = $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] itype_word(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
    itype_word = {imm, rs1, 3'b000, rd, 7'b001_0011};
  endfunction

  function automatic logic [31:0] rtype_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [4:0] rd);
    rtype_word = {f7, rs2, rs1, 3'b000, rd, 7'b011_0011};
  endfunction

  function automatic logic [31:0] btype_word(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
    btype_word = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b110_0011};
  endfunction

  function automatic logic [31:0] jtype_word(logic [20:0] off, logic [4:0] rd);
    jtype_word = {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
  endfunction

  task automatic abort_run;
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Weighted mix over x0..x7 so results feed later reads and x0 takes writes
  task automatic fill_memory;
    int unsigned pick;
    int          i;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [31:0] raw;
    for (i = 0; i < 64; i++) begin
      pick = urand(100);
      rd   = 5'(urand(8));
      rs1  = 5'(urand(8));
      rs2  = 5'(urand(8));
      boff = 13'((urand(7) + 1) * 4);
      joff = 21'((urand(7) + 1) * 4);
      raw  = $unsigned($random(seed));
      if (pick < 30) mem[i] = itype_word(raw[11:0], rs1, rd);
      else if (pick < 48) mem[i] = rtype_word(7'h00, rs2, rs1, rd);
      else if (pick < 60) mem[i] = rtype_word(7'h20, rs2, rs1, rd);
      else if (pick < 72) mem[i] = btype_word(boff, rs2, rs1, 3'b000);
      else if (pick < 84) mem[i] = btype_word(boff, rs2, rs1, 3'b001);
      else if (pick < 95) mem[i] = jtype_word(joff, rd);
      // Custom-0 major opcode is never legal here
      else mem[i] = {raw[31:7], 7'b000_1011};
      // Boot words load x1..x7 from x0 before any of them is read
      if (i < 7) mem[i] = itype_word(raw[11:0], 5'd0, 5'(i + 1));
    end
  endtask

  // Accept after 0 to 3 cycles and answer 1 to 4 cycles later
  always @(posedge clk_i) begin
    data_valid_i <= 1'b0;
    if (!rst_n_i) begin
      addr_ready_i <= 1'b0;
      acc_cnt      <= 0;
      rsp_pend     <= 1'b0;
    end else begin
      if (addr_valid_o && addr_ready_i) begin
        acc_draw     = urand(4);
        acc_cnt      <= acc_draw;
        addr_ready_i <= (acc_draw == 0);
        rsp_addr     <= addr_o;
        rsp_cnt      <= urand(4) + 1;
        rsp_pend     <= 1'b1;
      end else if (addr_valid_o) begin
        if (acc_cnt > 0) acc_cnt <= acc_cnt - 1;
        addr_ready_i <= (acc_cnt <= 1);
      end
      if (rsp_pend) begin
        if (rsp_cnt == 1) begin
          data_valid_i <= 1'b1;
          data_i       <= mem[rsp_addr[7:2]];
          rsp_pend     <= 1'b0;
        end else begin
          rsp_cnt <= rsp_cnt - 1;
        end
      end
    end
  end

  // Sampled on the falling edge where outputs are settled
  task automatic wait_event;
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      // Only a redirect holds a word back and it comes with an event
      if (!commit_valid_o && !except_raised_o) begin
        check_value("data_ready_o", 32'd1, 32'(data_ready_o));
      end
    end while (!(commit_valid_o || except_raised_o) && cycles < 100);
    if (!(commit_valid_o || except_raised_o)) begin
      $display("Timeout: no commit or exception within %0d cycles", cycles);
      abort_run();
    end
  endtask

  // One instruction of the reference ISA
  task automatic step_model;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [4:0]  rd;
    logic        legal;
    logic        wr;
    w     = mem[mpc[7:2]];
    rd    = w[11:7];
    a     = mreg[w[19:15]];
    b     = mreg[w[24:20]];
    legal = 1'b0;
    wr    = 1'b0;
    res   = '0;
    nxt   = mpc + 32'd4;
    case (w[6:0])
      7'b001_0011: if (w[14:12] == 3'b000) begin
        legal = 1'b1;
        wr    = 1'b1;
        res   = a + {{20{w[31]}}, w[31:20]};
      end
      7'b011_0011: if (w[14:12] == 3'b000 && (w[31:25] == 7'h00 || w[31:25] == 7'h20)) begin
        legal = 1'b1;
        wr    = 1'b1;
        res   = w[30] ? a - b : a + b;
      end
      7'b110_0011: if (w[14:13] == 2'b00) begin
        legal = 1'b1;
        // funct3 bit 0 selects BNE
        if ((a == b) != w[12]) begin
          nxt = mpc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'b110_1111: begin
        legal = 1'b1;
        wr    = 1'b1;
        res   = mpc + 32'd4;
        nxt   = mpc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: ;
    endcase
    if (!legal) begin
      check_value("except_raised_o", 32'd1, 32'(except_raised_o));
      check_value("except_code_o", 32'(core_pkg::EXC_ILLEGAL_INSTR), 32'(except_code_o));
      mpc = core_pkg::TRAP_PC;
    end else begin
      check_value("commit_valid_o", 32'd1, 32'(commit_valid_o));
      check_value("commit_pc_o", mpc, commit_pc_o);
      check_value("commit_rd_o", wr ? 32'(rd) : 32'd0, 32'(commit_rd_o));
      // x0 takes no write and reports zero
      check_value("commit_data_o", (wr && rd != 0) ? res : 32'd0, commit_data_o);
      if (wr && rd != 0) mreg[rd] = res;
      mpc = nxt;
    end
  endtask

  initial begin
    int n;
    seed  = 32'h4828da29;
    clk_i = 1'b0;
    rst_n_i      <= 1'b0;
    addr_ready_i <= 1'b0;
    data_i       <= '0;
    data_valid_i <= 1'b0;
    fill_memory();
    for (n = 0; n < 32; n++) mreg[n] = '0;
    mpc = core_pkg::BOOT_PC;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("addr_o", core_pkg::BOOT_PC, addr_o);
    check_value("addr_valid_o", 32'd0, 32'(addr_valid_o));
    check_value("data_ready_o", 32'd1, 32'(data_ready_o));
    check_value("commit_valid_o", 32'd0, 32'(commit_valid_o));
    check_value("except_raised_o", 32'd0, 32'(except_raised_o));
    // First event must be the word at BOOT_PC
    for (n = 0; n < 400; n++) begin
      wait_event();
      step_model();
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/core_pkg.sv
design/fetch_if.sv
design/resolve_if.sv
design/branch_predictor.sv
design/front_end.sv
design/back_end.sv
design/data_path.sv
verification/data_path_props.sv
verification/tb_data_path.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data_path testbench, exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
  --top-module tb_data_path -o sim_tb_data_path &&
./obj_dir/sim_tb_data_path || exit 1
